// File: area_pkg.sv
////////////////////////////////////////
// Area test shared definitions
// Sizes, counter seeds and increments,
// and the word types used by every block
////////////////////////////////////////

package area_pkg;

  // Memory bank geometry
  localparam int BANKS  = 8;
  localparam int ADDR_W = 4;
  // Also the clear sweep length in cycles
  localparam int DEPTH  = 16;
  localparam int DATA_W = 16;

  // Pattern counter width
  localparam int CNT_W  = 32;

  // Board LED count
  localparam int LED_W  = 8;

  typedef logic [ADDR_W-1:0]       addr_t;
  typedef logic [DATA_W-1:0]       data_t;
  typedef logic [CNT_W-1:0]        cnt_t;
  // Full 16x16 product
  typedef logic [2*DATA_W-1:0]     prod_t;
  // One bit per memory block
  typedef logic [BANKS-1:0]        bank_mask_t;
  // Block k read word sits at bits k*DATA_W and up
  typedef logic [BANKS*DATA_W-1:0] bank_data_t;

  // Counter start values after reset
  localparam cnt_t SEED_A = 32'h12345678;
  localparam cnt_t SEED_B = 32'h87654321;

  // Counter increments per accepted step
  localparam cnt_t INC_A  = 32'h00012345;
  localparam cnt_t INC_B  = 32'h00054321;

endpackage

// File: pattern_if.sv
////////////////////////////////////////
// Write pattern link
// Carries one memory access per strobe
// from the pattern source to the bank
////////////////////////////////////////

`timescale 1ns/1ps

interface pattern_if;

  // One access this cycle, write and read
  logic                   adv;
  // Clear sweep in progress
  logic                   clearing;
  // Shared address for all blocks
  area_pkg::addr_t        addr;
  // Low half of counter A xor counter B
  area_pkg::data_t        wdata;
  // Per-block write select
  area_pkg::bank_mask_t   wmask;

  // Source side drives everything
  modport src (
    output adv, clearing, addr, wdata, wmask
  );

  // Bank has no way to stall the source
  modport bank (
    input adv, clearing, addr, wdata, wmask
  );

endinterface

// File: pattern_source.sv
////////////////////////////////////////
// Pattern source
// Clears the memories after reset, then
// turns each step into one write access
////////////////////////////////////////

`timescale 1ns/1ps

module pattern_source
  import area_pkg::*;
(
  input  logic   CLK,
  input  logic   rst_n,
  input  logic   step,
  output logic   ready,
  pattern_if.src pat
);

  // Idle is the single cycle after reset release
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SWEEP,
    ST_RUN
  } state_t;

  state_t state;
  cnt_t   cnt_a;
  cnt_t   cnt_b;
  // Shared address, doubles as the sweep counter
  addr_t  addr;
  logic   clearing;
  logic   take_step;
  logic   sweep_last;

  assign clearing   = (state == ST_SWEEP);
  assign ready      = (state == ST_RUN);
  // Steps before ready are simply ignored
  assign take_step  = ready & step;
  assign sweep_last = (addr == addr_t'(DEPTH - 1));

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE:  state <= ST_SWEEP;
        ST_SWEEP: if (sweep_last) state <= ST_RUN;
        ST_RUN:   state <= ST_RUN;
        default:  state <= ST_IDLE;
      endcase
    end
  end

  // Address wraps back to zero as the sweep ends
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      addr  <= '0;
      cnt_a <= SEED_A;
      cnt_b <= SEED_B;
    end else begin
      if (clearing || take_step) addr <= addr + addr_t'(1);
      if (take_step) begin
        cnt_a <= cnt_a + INC_A;
        cnt_b <= cnt_b + INC_B;
      end
    end
  end

  // Current pattern goes out before the increment
  assign pat.adv      = clearing | take_step;
  assign pat.clearing = clearing;
  assign pat.addr     = addr;
  // Sweep writes zero to every block
  assign pat.wdata    = clearing ? '0 : cnt_a[DATA_W-1:0] ^ cnt_b[DATA_W-1:0];
  assign pat.wmask    = clearing ? '1 : cnt_a[BANKS-1:0] ^ cnt_b[BANKS-1:0];

endmodule

// File: memory_block.sv
////////////////////////////////////////
// Single-port memory block
// Registered read returns old contents
////////////////////////////////////////

`timescale 1ns/1ps

module memory_block
  import area_pkg::*;
(
  input  logic  CLK,
  input  logic  rst_n,
  input  logic  en,
  input  logic  we,
  input  addr_t addr,
  input  data_t wdata,
  output data_t rdata
);

  data_t mem [DEPTH];

  // Write port
  always_ff @(posedge CLK) begin
    if (we) mem[addr] <= wdata;
  end

  // Read port, en loads the output register
  // Same-edge write is not visible here
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      rdata <= '0;
    end else if (en) begin
      rdata <= mem[addr];
    end
  end

endmodule

// File: bram_bank.sv
////////////////////////////////////////
// Memory bank
// Eight blocks on one shared address,
// per-block data and write select
////////////////////////////////////////

`timescale 1ns/1ps

module bram_bank
  import area_pkg::*;
(
  input  logic       CLK,
  input  logic       rst_n,
  pattern_if.bank    pat,
  output logic       rd_valid,
  output bank_data_t rd_data
);

  // Reads only count for real steps
  // Keeps the read registers at zero through the sweep
  logic rd_en;

  assign rd_en = pat.adv & ~pat.clearing;

  for (genvar k = 0; k < BANKS; k++) begin : g_blk
    data_t blk_wdata;
    logic  blk_we;
    data_t blk_rdata;

    // Block index folded into the low bits of the word
    assign blk_wdata = pat.clearing ? '0 : pat.wdata ^ data_t'(k);
    assign blk_we    = pat.adv & pat.wmask[k];

    memory_block u_mem (
      .CLK   (CLK),
      .rst_n (rst_n),
      .en    (rd_en),
      .we    (blk_we),
      .addr  (pat.addr),
      .wdata (blk_wdata),
      .rdata (blk_rdata)
    );

    assign rd_data[k*DATA_W +: DATA_W] = blk_rdata;
  end

  // Matches the one-cycle read latency of the blocks
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;
    end
  end

endmodule

// File: led_mixer.sv
////////////////////////////////////////
// LED mixer
// Multiplies and folds the bank reads,
// then rotates the results onto LEDs
////////////////////////////////////////

`timescale 1ns/1ps

module led_mixer
  import area_pkg::*;
(
  input  logic             CLK,
  input  logic             rst_n,
  input  logic             rd_valid,
  input  bank_data_t       rd_data,
  output logic [LED_W-1:0] led
);

  data_t      words [BANKS];
  prod_t      prods [BANKS/2];
  data_t      word_xor;
  prod_t      mult_xor;
  // Rotating shift register for the upper LEDs
  data_t      shift_q;
  // Low half of the product XOR from the last completed read
  data_t      mult_q;
  // Bit selector, counts steps mod 16
  logic [3:0] sel;

  for (genvar i = 0; i < BANKS; i++) begin : g_word
    assign words[i] = rd_data[i*DATA_W +: DATA_W];
  end

  // Block i pairs with block i+4
  for (genvar i = 0; i < BANKS/2; i++) begin : g_mult
    assign prods[i] = prod_t'(words[i]) * prod_t'(words[i + BANKS/2]);
  end

  // XOR trees
  always_comb begin
    word_xor = '0;
    for (int i = 0; i < BANKS; i++) begin
      word_xor = word_xor ^ words[i];
    end
    mult_xor = '0;
    for (int i = 0; i < BANKS/2; i++) begin
      mult_xor = mult_xor ^ prods[i];
    end
  end

  // Advance once per completed read
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      shift_q <= '0;
      mult_q  <= '0;
      sel     <= '0;
    end else if (rd_valid) begin
      // Rotate left by one, then fold in the word XOR
      shift_q <= {shift_q[DATA_W-2:0], shift_q[DATA_W-1]} ^ word_xor;
      // Held so a following read cannot reach the LEDs early
      mult_q  <= mult_xor[DATA_W-1:0];
      sel     <= sel + 4'd1;
    end
  end

  // Upper LEDs show the top of the shift register
  assign led[LED_W-1:LED_W/2] = shift_q[DATA_W-1 -: LED_W/2];

  // Lower LEDs tap the product XOR, taps a quarter turn apart
  // 4-bit index sum wraps mod 16 on its own
  for (genvar i = 0; i < LED_W/2; i++) begin : g_led
    assign led[i] = mult_q[sel + 4'(4*i)];
  end

endmodule

// File: area_top.sv
////////////////////////////////////////
// Area test top level
// Pattern source, memory bank and LED
// mixer behind plain board ports
////////////////////////////////////////

`timescale 1ns/1ps

module area_top
  import area_pkg::*;
(
  input  logic             CLK,
  input  logic             rst_n,
  input  logic             step,
  output logic             ready,
  output logic [LED_W-1:0] led
);

  // Bank to mixer read path
  logic       rd_valid;
  bank_data_t rd_data;

  pattern_if pat_if ();

  pattern_source u_source (
    .CLK   (CLK),
    .rst_n (rst_n),
    .step  (step),
    .ready (ready),
    .pat   (pat_if.src)
  );

  bram_bank u_bank (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .pat      (pat_if.bank),
    .rd_valid (rd_valid),
    .rd_data  (rd_data)
  );

  led_mixer u_mixer (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .rd_valid (rd_valid),
    .rd_data  (rd_data),
    .led      (led)
  );

endmodule

// File: tb_area_top.sv
////////////////////////////////////////
// Area test testbench
// Steps the design and checks ready and
// the LEDs against a reference model
////////////////////////////////////////

`timescale 1ns/1ps

module tb_area_top
  import area_pkg::*;
();

  localparam int CLK_HALF_NS  = 20;
  localparam int RESET_CYCLES = 8;
  localparam int SPACED_STEPS = 20;
  localparam int BURST_STEPS  = 40;
  localparam int RANDOM_STEPS = 200;
  localparam int AFTER_STEPS  = 20;
  // About 300 steps with up to 4 cycles each, two resets and sweeps,
  // roughly 60 us of traffic with a wide margin
  localparam int WATCHDOG_NS  = 200_000;

  logic             CLK   = 1'b0;
  logic             rst_n = 1'b0;
  logic             step  = 1'b0;
  logic             ready;
  logic [LED_W-1:0] led;

  // Reference model state
  data_t      mem_m [BANKS][DEPTH];
  cnt_t       cnt_a_m;
  cnt_t       cnt_b_m;
  addr_t      addr_m;
  data_t      shift_m;
  int         n_steps;
  int         total_steps = 0;
  logic [31:0] rng_state  = 32'h1b39dc7b;

  // Expected values, two cycles of step-to-LED latency
  logic             stage1_v   = 1'b0;
  logic             stage2_v   = 1'b0;
  logic [LED_W-1:0] stage1_led = '0;
  logic [LED_W-1:0] stage2_led = '0;
  logic [LED_W-1:0] exp_led    = '0;
  logic             exp_ready  = 1'b0;
  int               since_rel  = 0;
  int               rst_cycles = 0;

  area_top u_area_top (
    .CLK   (CLK),
    .rst_n (rst_n),
    .step  (step),
    .ready (ready),
    .led   (led)
  );

  always #(CLK_HALF_NS) CLK = ~CLK;

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // State right after the clear sweep
  function automatic void model_reset();
    for (int k = 0; k < BANKS; k++) begin
      for (int a = 0; a < DEPTH; a++) begin
        mem_m[k][a] = '0;
      end
    end
    cnt_a_m = SEED_A;
    cnt_b_m = SEED_B;
    addr_m  = '0;
    shift_m = '0;
    n_steps = 0;
  endfunction

  // Applies one step and returns the LEDs it leads to
  function automatic logic [LED_W-1:0] model_step();
    data_t            rd [BANKS];
    data_t            wdata;
    bank_mask_t       mask;
    data_t            x;
    prod_t            m;
    data_t            m_lo;
    logic [3:0]       bit_idx;
    logic [LED_W-1:0] res;
    wdata = cnt_a_m[DATA_W-1:0] ^ cnt_b_m[DATA_W-1:0];
    mask  = cnt_a_m[BANKS-1:0] ^ cnt_b_m[BANKS-1:0];
    // Read old word first, then write
    for (int k = 0; k < BANKS; k++) begin
      rd[k] = mem_m[k][addr_m];
      if (mask[k]) mem_m[k][addr_m] = wdata ^ data_t'(k);
    end
    x = '0;
    for (int k = 0; k < BANKS; k++) begin
      x = x ^ rd[k];
    end
    m = '0;
    for (int i = 0; i < BANKS/2; i++) begin
      m = m ^ (prod_t'(rd[i]) * prod_t'(rd[i + BANKS/2]));
    end
    shift_m = {shift_m[DATA_W-2:0], shift_m[DATA_W-1]} ^ x;
    n_steps = n_steps + 1;
    m_lo    = m[DATA_W-1:0];
    res[7:4] = shift_m[15:12];
    for (int i = 0; i < 4; i++) begin
      bit_idx = 4'((n_steps + 4*i) % 16);
      res[i]  = m_lo[bit_idx];
    end
    cnt_a_m = cnt_a_m + INC_A;
    cnt_b_m = cnt_b_m + INC_B;
    addr_m  = addr_m + 4'd1;
    return res;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp_val);
    if (got !== exp_val) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp_val);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  // Compare at the falling edge, where inputs and outputs are settled
  always @(negedge CLK) begin
    if (!rst_n) begin
      // The DUT is reset only after one rising edge with rst_n low
      if (rst_cycles > 0) begin
        check_value("led", 32'(led), 32'h0);
        check_value("ready", 32'(ready), 32'h0);
      end
      rst_cycles = rst_cycles + 1;
      model_reset();
      stage1_v  = 1'b0;
      stage2_v  = 1'b0;
      exp_led   = '0;
      exp_ready = 1'b0;
      since_rel = 0;
    end else begin
      rst_cycles = 0;
      if (stage2_v) exp_led = stage2_led;
      // Idle cycle plus DEPTH sweep cycles before ready
      exp_ready = (since_rel >= DEPTH + 1);
      check_value("ready", 32'(ready), 32'(exp_ready));
      check_value("led", 32'(led), 32'(exp_led));
      stage2_v   = stage1_v;
      stage2_led = stage1_led;
      stage1_v   = step & exp_ready;
      if (stage1_v) begin
        stage1_led  = model_step();
        total_steps = total_steps + 1;
      end
      if (since_rel <= DEPTH) since_rel = since_rel + 1;
    end
  end

  task automatic drive_step(input logic value);
    @(posedge CLK);
    #2;
    step = value;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_step(1'b0);
  endtask

  task automatic hold_reset();
    rst_n = 1'b0;
    step  = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #2;
    rst_n = 1'b1;
  endtask

  // Steps pulsed during the sweep must be dropped
  task automatic sweep_with_steps();
    for (int i = 0; i < 12; i++) begin
      drive_step((i % 2) == 0);
    end
    drive_step(1'b0);
  endtask

  task automatic wait_ready();
    int waited;
    waited = 0;
    while (ready !== 1'b1) begin
      if (waited > DEPTH + 4) begin
        $display("Error: ready did not rise after the clear sweep");
        $display("Verification failed");
        $fatal(1);
      end
      drive_step(1'b0);
      waited = waited + 1;
    end
  endtask

  task automatic random_steps(input int count);
    repeat (count) begin
      drive_step(1'b1);
      idle_cycles(int'(next_random() % 4));
    end
  endtask

  initial begin
    hold_reset();
    sweep_with_steps();
    wait_ready();
    repeat (SPACED_STEPS) begin
      drive_step(1'b1);
      idle_cycles(3);
    end
    // Wraps the address more than twice
    repeat (BURST_STEPS) drive_step(1'b1);
    idle_cycles(3);
    random_steps(RANDOM_STEPS);
    idle_cycles(6);
    hold_reset();
    sweep_with_steps();
    wait_ready();
    random_steps(AFTER_STEPS);
    idle_cycles(4);
    check_value("total_steps", 32'(total_steps),
                32'(SPACED_STEPS + BURST_STEPS + RANDOM_STEPS + AFTER_STEPS));
    $display("Verification passed");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Error: simulation timed out before all steps were done");
    $display("Verification failed");
    $fatal(1);
  end

endmodule

// File: build.f
area_pkg.sv
pattern_if.sv
pattern_source.sv
memory_block.sv
bram_bank.sv
led_mixer.sv
area_top.sv
tb_area_top.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the area test with Verilator and runs the testbench

cd "$(dirname "$0")" || exit 1

verilator --binary -f build.f --top-module tb_area_top -o sim_area
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_area 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q "Verification passed"; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi
